/* fcvt_pkg.sv */
/*
 * FCVT shared definitions
 * Widths, opcodes, rounding modes and the packed payloads that travel
 * between the stages of the float/integer conversion pipeline
 */

package fcvt_pkg;

  // --------------------------------------------------
  // Widths and format constants
  // --------------------------------------------------
  localparam int DATA_W    = 32;  // Operand and result width
  localparam int EXP_BITS  = 8;   // binary32 exponent field
  localparam int MAN_BITS  = 23;  // binary32 stored mantissa
  localparam int BIAS      = 127; // binary32 exponent bias
  localparam int INT_MAN_W = 32;  // Holds a whole integer or 1.mantissa
  localparam int INT_EXP_W = 10;  // Signed, covers -149 .. +158
  localparam int LZC_W     = 5;   // Leading-zero count of INT_MAN_W bits

  // Special result values
  localparam logic [DATA_W-1:0] QNAN      = 32'h7fc00000; // Canonical quiet NaN
  localparam logic [DATA_W-1:0] INT_MAX_S = 32'h7fffffff;
  localparam logic [DATA_W-1:0] INT_MIN_S = 32'h80000000;
  localparam logic [DATA_W-1:0] UINT_MAX  = 32'hffffffff;

  // --------------------------------------------------
  // Opcodes and rounding modes
  // --------------------------------------------------
  typedef enum logic {
    OP_F2I = 1'b0, // binary32 to integer
    OP_I2F = 1'b1  // Integer to binary32
  } op_e;

  // Same encoding as the RISC-V frm field
  typedef enum logic [2:0] {
    RNE = 3'b000, // Nearest, ties to even
    RTZ = 3'b001, // Toward zero
    RDN = 3'b010, // Toward -inf
    RUP = 3'b011, // Toward +inf
    RMM = 3'b100  // Nearest, ties away from zero
  } rnd_mode_e;

  // --------------------------------------------------
  // Packed payloads
  // --------------------------------------------------
  typedef struct packed {
    logic NV; // Invalid
    logic DZ; // Divide by zero, never raised by a cast
    logic OF; // Overflow
    logic UF; // Underflow
    logic NX; // Inexact
  } status_t;

  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_quiet;
  } fp_info_t;

  typedef struct packed {
    logic [DATA_W-1:0] operand;
    op_e               op;
    logic              op_mod;   // 1 selects unsigned integers
    rnd_mode_e         rnd_mode;
  } fcvt_req_t;

  // Normalized operand, registered in the mid stage
  typedef struct packed {
    logic                        sign;
    logic signed [INT_EXP_W-1:0] exp;       // Unbiased exponent
    logic [INT_MAN_W-1:0]        mant;      // MSB set unless zero
    fp_info_t                    info;
    logic                        mant_zero; // Integer zero on I2F
    op_e                         op;
    logic                        op_mod;
    rnd_mode_e                   rnd_mode;
  } fcvt_norm_t;

  typedef struct packed {
    logic [DATA_W-1:0] result;
    status_t           status;
  } fcvt_resp_t;

endpackage

/* fcvt_lzc.sv */
/*
 * Leading-zero counter
 * Priority search from the MSB; flags an all-zero input
 */

`timescale 1ns/100ps

module fcvt_lzc (
  input  logic [fcvt_pkg::INT_MAN_W-1:0] in_i,
  output logic [fcvt_pkg::LZC_W-1:0]     cnt_o,
  output logic                           empty_o
);

  // Scan upward so the highest set bit wins the last assignment
  always_comb begin
    cnt_o = '0; // Also the count for an empty input
    for (int i = 0; i < fcvt_pkg::INT_MAN_W; i++) begin
      if (in_i[i]) begin
        cnt_o = fcvt_pkg::LZC_W'(fcvt_pkg::INT_MAN_W - 1 - i);
      end
    end
  end

  // No bit set at all, used as integer zero
  assign empty_o = ~(|in_i);

endmodule

/* fcvt_normalizer.sv */
/*
 * FCVT normalizer
 * Classifies the binary32 operand, takes the integer magnitude for I2F and
 * left-aligns the mantissa with the matching unbiased exponent
 */

`timescale 1ns/100ps

module fcvt_normalizer (
  input  fcvt_pkg::fcvt_req_t  req_i,
  output fcvt_pkg::fcvt_norm_t norm_o
);

  logic                                 is_i2f;
  logic [fcvt_pkg::EXP_BITS-1:0]        exp_field;
  logic [fcvt_pkg::MAN_BITS-1:0]        man_field;
  fcvt_pkg::fp_info_t                   info;
  logic                                 int_sign;
  logic [fcvt_pkg::INT_MAN_W-1:0]       int_mant; // Integer magnitude
  logic [fcvt_pkg::INT_MAN_W-1:0]       fp_mant;  // Hidden bit plus fraction
  logic [fcvt_pkg::INT_MAN_W-1:0]       enc_mant; // Selected by operation
  logic [fcvt_pkg::LZC_W-1:0]           shamt;    // Renormalization shift
  logic                                 mant_zero;
  logic signed [fcvt_pkg::INT_EXP_W-1:0] fp_exp, int_exp;

  assign is_i2f    = (req_i.op == fcvt_pkg::OP_I2F);
  assign exp_field = req_i.operand[fcvt_pkg::MAN_BITS +: fcvt_pkg::EXP_BITS];
  assign man_field = req_i.operand[fcvt_pkg::MAN_BITS-1:0];

  // --------------------------------------------------
  // Classification
  // --------------------------------------------------
  always_comb begin
    info.is_normal     = (exp_field != '0) && (exp_field != '1);
    info.is_subnormal  = (exp_field == '0) && (man_field != '0);
    info.is_zero       = (exp_field == '0) && (man_field == '0);
    info.is_inf        = (exp_field == '1) && (man_field == '0);
    info.is_nan        = (exp_field == '1) && (man_field != '0);
    info.is_signalling = info.is_nan && !man_field[fcvt_pkg::MAN_BITS-1]; // MSB clear
    info.is_quiet      = info.is_nan && man_field[fcvt_pkg::MAN_BITS-1];
  end

  // Only signed integers can be negative
  assign int_sign = req_i.operand[fcvt_pkg::DATA_W-1] & ~req_i.op_mod;
  assign int_mant = int_sign ? -req_i.operand : req_i.operand;
  // Right aligned, zero padded above the hidden bit
  assign fp_mant  = fcvt_pkg::INT_MAN_W'({info.is_normal, man_field});
  assign enc_mant = is_i2f ? int_mant : fp_mant;

  // --------------------------------------------------
  // Renormalization
  // --------------------------------------------------
  fcvt_lzc u_lzc (
    .in_i    (enc_mant),
    .cnt_o   (shamt),
    .empty_o (mant_zero)
  );

  // Subnormals count as exponent 1; the padding above the hidden bit is added back
  assign fp_exp = signed'(fcvt_pkg::INT_EXP_W'(exp_field))
                + signed'(fcvt_pkg::INT_EXP_W'(info.is_subnormal))
                - signed'(fcvt_pkg::INT_EXP_W'(fcvt_pkg::BIAS))
                - signed'(fcvt_pkg::INT_EXP_W'(shamt))
                + signed'(fcvt_pkg::INT_EXP_W'(fcvt_pkg::INT_MAN_W - 1 - fcvt_pkg::MAN_BITS));
  assign int_exp = signed'(fcvt_pkg::INT_EXP_W'(fcvt_pkg::INT_MAN_W - 1))
                 - signed'(fcvt_pkg::INT_EXP_W'(shamt)); // Position of the leading one

  always_comb begin
    norm_o.sign      = is_i2f ? int_sign : req_i.operand[fcvt_pkg::DATA_W-1];
    norm_o.exp       = is_i2f ? int_exp : fp_exp;
    norm_o.mant      = enc_mant << shamt; // Leading one lands in the MSB
    norm_o.info      = info;
    norm_o.mant_zero = mant_zero;
    norm_o.op        = req_i.op;
    norm_o.op_mod    = req_i.op_mod;
    norm_o.rnd_mode  = req_i.rnd_mode;
  end

endmodule

/* fcvt_pipe_stage.sv */
/*
 * Elastic pipeline register
 * One valid/ready stage with synchronous flush, used for any payload width
 */

`timescale 1ns/100ps

module fcvt_pipe_stage #(
  parameter int Width = 32 // Payload bits
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             flush_i,     // Drops the held item
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  logic [Width-1:0] in_data_i,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic [Width-1:0] out_data_o
);

  logic             valid_q;
  logic [Width-1:0] data_q;

  // Accept when downstream takes our item or we only hold a bubble
  assign in_ready_o = out_ready_i | ~valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0; // In-flight item discarded
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // Payload only moves on an accepted transfer
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) data_q <= in_data_i;
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

/* fcvt_cast_round.sv */
/*
 * FCVT cast and round
 * Places the normalized mantissa for the target format, rounds it,
 * substitutes special results and raises the status flags
 */

`timescale 1ns/100ps

module fcvt_cast_round (
  input  fcvt_pkg::fcvt_norm_t norm_i,
  output fcvt_pkg::fcvt_resp_t resp_o
);

  logic                                  dst_is_int; // F2I
  logic signed [fcvt_pkg::INT_EXP_W-1:0] exp_s;
  logic signed [fcvt_pkg::INT_EXP_W-1:0] dest_exp;   // Rebiased for binary32

  assign dst_is_int = (norm_i.op == fcvt_pkg::OP_F2I);
  assign exp_s      = norm_i.exp;
  assign dest_exp   = exp_s + signed'(fcvt_pkg::INT_EXP_W'(fcvt_pkg::BIAS));

  // --------------------------------------------------
  // Casting
  // --------------------------------------------------
  logic [2*fcvt_pkg::INT_MAN_W:0] preshift_mant; // Mantissa at the shifter top
  logic [2*fcvt_pkg::INT_MAN_W:0] dest_mant;     // After the denormalizing shift
  logic [fcvt_pkg::LZC_W:0]       denorm_shamt;
  logic [fcvt_pkg::MAN_BITS-1:0]  final_mant;
  logic [fcvt_pkg::DATA_W-1:0]    final_int;
  logic [1:0]                     fp_rs, int_rs, rs; // Round and sticky bits
  logic                           of_before_round;

  always_comb begin
    preshift_mant   = {norm_i.mant, {(fcvt_pkg::INT_MAN_W+1){1'b0}}};
    denorm_shamt    = '0; // binary32 mantissa already in place
    of_before_round = 1'b0;
    if (dst_is_int) begin
      // Unsigned range reaches one binade higher
      if (exp_s >= signed'(fcvt_pkg::INT_EXP_W'(fcvt_pkg::DATA_W - 1 + int'(norm_i.op_mod))))
      begin
        of_before_round = 1'b1; // Keep shift at zero
      end else if (exp_s < -1) begin
        // Below one half, everything ends up in sticky
        denorm_shamt = (fcvt_pkg::LZC_W+1)'(fcvt_pkg::DATA_W + 1);
      end else begin
        denorm_shamt = (fcvt_pkg::LZC_W+1)'(fcvt_pkg::DATA_W - 1 - exp_s); // Integer place
      end
    end
  end

  assign dest_mant = preshift_mant >> denorm_shamt;

  // Hidden bit sits in the top bit and is dropped for binary32
  assign {final_mant, fp_rs[1]} =
      dest_mant[2*fcvt_pkg::INT_MAN_W-1 -: fcvt_pkg::MAN_BITS+1];
  assign {final_int, int_rs[1]} =
      dest_mant[2*fcvt_pkg::INT_MAN_W -: fcvt_pkg::DATA_W+1];
  assign fp_rs[0]  = |dest_mant[2*fcvt_pkg::INT_MAN_W-fcvt_pkg::MAN_BITS-2:0];
  assign int_rs[0] = |dest_mant[2*fcvt_pkg::INT_MAN_W-fcvt_pkg::DATA_W-1:0];
  assign rs        = dst_is_int ? int_rs : fp_rs;

  // --------------------------------------------------
  // Rounding
  // --------------------------------------------------
  logic [fcvt_pkg::DATA_W-1:0] pre_round_abs;
  logic [fcvt_pkg::DATA_W-1:0] rounded_abs;
  logic [fcvt_pkg::DATA_W-1:0] rounded_int_res; // Two's complement
  logic                        round_up;
  logic                        int_res_zero;
  logic                        of_after_round, uf_after_round;

  assign pre_round_abs = dst_is_int ? final_int
                                    : fcvt_pkg::DATA_W'({dest_exp[fcvt_pkg::EXP_BITS-1:0],
                                                         final_mant});

  always_comb begin
    case (norm_i.rnd_mode)
      fcvt_pkg::RNE: round_up = rs[1] & (rs[0] | pre_round_abs[0]); // Tie goes to even
      fcvt_pkg::RTZ: round_up = 1'b0;
      fcvt_pkg::RDN: round_up = (|rs) & norm_i.sign;
      fcvt_pkg::RUP: round_up = (|rs) & ~norm_i.sign;
      fcvt_pkg::RMM: round_up = rs[1];                              // Tie away from zero
      default:       round_up = 1'b0;
    endcase
  end

  // Carry out of the mantissa bumps the exponent
  assign rounded_abs     = pre_round_abs + fcvt_pkg::DATA_W'(round_up);
  assign rounded_int_res = norm_i.sign ? -rounded_abs : rounded_abs;
  assign int_res_zero    = (rounded_int_res == '0);

  // Exponent field of the rounded binary32
  assign of_after_round = &rounded_abs[fcvt_pkg::DATA_W-2 -: fcvt_pkg::EXP_BITS];
  assign uf_after_round = ~(|rounded_abs[fcvt_pkg::DATA_W-2 -: fcvt_pkg::EXP_BITS]);

  // --------------------------------------------------
  // Special cases and flags
  // --------------------------------------------------
  logic                        int_is_special;
  logic [fcvt_pkg::DATA_W-1:0] int_special_res;
  logic [fcvt_pkg::DATA_W-1:0] fp_result;
  fcvt_pkg::status_t           fp_status, int_status;

  // NaN, inf, out of range, or a negative that survives rounding into unsigned
  assign int_is_special = norm_i.info.is_nan | norm_i.info.is_inf | of_before_round |
                          (norm_i.sign & norm_i.op_mod & ~int_res_zero);

  always_comb begin
    if (!norm_i.sign || norm_i.info.is_nan) begin
      int_special_res = norm_i.op_mod ? fcvt_pkg::UINT_MAX : fcvt_pkg::INT_MAX_S;
    end else begin
      int_special_res = norm_i.op_mod ? '0 : fcvt_pkg::INT_MIN_S; // Saturate low
    end
  end

  // Float results only come from integers here, so zero is always +0
  assign fp_result = norm_i.mant_zero ? '0
                                      : {norm_i.sign, rounded_abs[fcvt_pkg::DATA_W-2:0]};

  always_comb begin
    fp_status    = '0;
    fp_status.NV = of_after_round;                  // Integer too large for binary32
    fp_status.NX = |fp_rs;
    fp_status.UF = uf_after_round & fp_status.NX;   // Tiny and inexact
    int_status   = '0;
    if (int_is_special) int_status.NV = 1'b1;       // Only NV on any special
    else                int_status.NX = |int_rs;
  end

  always_comb begin
    if (dst_is_int) begin
      resp_o.result = int_is_special ? int_special_res : rounded_int_res;
      resp_o.status = int_status;
    end else begin
      resp_o.result = fp_result;
      resp_o.status = fp_status;
    end
  end

endmodule

/* fcvt_top.sv */
/*
 * FCVT top level
 * binary32 <-> 32-bit integer conversion, two stage valid/ready pipeline:
 * normalize, mid register, cast and round, output register
 */

`timescale 1ns/100ps

module fcvt_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  fcvt_pkg::fcvt_req_t  req_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic                 flush_i,     // Kills both stages
  output fcvt_pkg::fcvt_resp_t resp_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic                 busy_o       // Item held in either stage
);

  fcvt_pkg::fcvt_norm_t norm_d, norm_q;
  fcvt_pkg::fcvt_resp_t resp_d;
  logic                 mid_valid;
  logic                 mid_ready; // Out stage accepts

  // --------------------------------------------------
  // Stage 1: normalize and register
  // --------------------------------------------------
  fcvt_normalizer u_normalizer (
    .req_i  (req_i),
    .norm_o (norm_d)
  );

  fcvt_pipe_stage #(
    .Width ($bits(fcvt_pkg::fcvt_norm_t))
  ) mid_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (norm_d),
    .out_valid_o (mid_valid),
    .out_ready_i (mid_ready),
    .out_data_o  (norm_q)
  );

  // --------------------------------------------------
  // Stage 2: cast, round and register
  // --------------------------------------------------
  fcvt_cast_round u_cast_round (
    .norm_i (norm_q),
    .resp_o (resp_d)
  );

  fcvt_pipe_stage #(
    .Width ($bits(fcvt_pkg::fcvt_resp_t))
  ) out_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (mid_valid),
    .in_ready_o  (mid_ready),
    .in_data_i   (resp_d),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (resp_o)
  );

  assign busy_o = mid_valid | out_valid_o;

endmodule

/* tb_clk_gen.sv */
/*
 * Testbench clock and reset
 * 100 ns clock, reset held low for the first five cycles
 */

`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o; // Half period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1; // Released on a falling edge
  end

endmodule

/* tb_fcvt_properties.sv */
/*
 * FCVT handshake properties
 * Reset values, output stability under back-pressure, flush
 */

`timescale 1ns/100ps

module tb_fcvt_properties (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic                 flush_i,
  input logic                 out_valid_o,
  input logic                 out_ready_i,
  input logic                 busy_o,
  input fcvt_pkg::fcvt_resp_t resp_o
);

  int fail_cnt = 0; // Failed assertions so far

  // Nothing in flight while reset is held
  reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !out_valid_o && !busy_o)
    else begin
      $error("Output valid or busy high during reset");
      fail_cnt++;
    end

  // A stalled response must hold until taken, unless flushed
  hold_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(resp_o))
    else begin
      $error("Stalled response changed or vanished");
      fail_cnt++;
    end

  // Flush wins over a request taken in the same cycle
  flush_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      flush_i |=> !busy_o)
    else begin
      $error("Pipeline still busy after a flush");
      fail_cnt++;
    end

endmodule

bind fcvt_top tb_fcvt_properties u_props (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .flush_i     (flush_i),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .busy_o      (busy_o),
  .resp_o      (resp_o)
);

/* tb_fcvt.sv */
/*
 * FCVT testbench
 * Directed and random conversions through the pipeline, checked against
 * a reference model in request order under random back-pressure
 */

`timescale 1ns/100ps

module tb_fcvt;

  localparam int NUM_RANDOM = 300;
  localparam int NUM_TESTS  = 16 * 10 + 8 * 10 + NUM_RANDOM; // Directed sweeps plus random

  logic                 clk, rst_n;
  logic                 in_valid, in_ready, flush;
  logic                 out_valid, out_ready, busy;
  fcvt_pkg::fcvt_req_t  req;
  fcvt_pkg::fcvt_resp_t resp;
  fcvt_pkg::fcvt_resp_t exp_q[$]; // Expected responses in flight
  logic [31:0]          lfsr_q = 32'h2b61;
  logic                 accepted;
  int                   err_result = 0;
  int                   err_status = 0;
  int                   err_hs     = 0;

  tb_clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

  fcvt_top UUT (
    .clk_i (clk), .rst_n_i (rst_n), .req_i (req), .in_valid_i (in_valid),
    .in_ready_o (in_ready), .flush_i (flush), .resp_o (resp),
    .out_valid_o (out_valid), .out_ready_i (out_ready), .busy_o (busy)
  );

  // --------------------------------------------------
  // Random source
  // --------------------------------------------------
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h8020_0003 : lfsr_q >> 1; // x^32+x^22+x^2+x+1
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  // rem and half are the discarded part and its halfway point
  function automatic bit round_inc(fcvt_pkg::rnd_mode_e rm, logic sign, logic lsb,
                                   longint unsigned rem, longint unsigned half);
    case (rm)
      fcvt_pkg::RNE: return (rem > half) || (rem == half && lsb);
      fcvt_pkg::RDN: return (rem != 0) && sign;
      fcvt_pkg::RUP: return (rem != 0) && !sign;
      fcvt_pkg::RMM: return rem >= half;
      default:       return 1'b0; // RTZ truncates
    endcase
  endfunction

  function automatic fcvt_pkg::fcvt_resp_t model_i2f(logic [31:0] x, logic uns,
                                                      fcvt_pkg::rnd_mode_e rm);
    fcvt_pkg::fcvt_resp_t r;
    logic sign;
    logic [31:0] mag;
    int p, s;
    longint unsigned k, rem, half;
    r    = '0;
    sign = x[31] & ~uns;
    mag  = sign ? -x : x;
    if (mag == 0) return r; // +0, exact
    p = 0;
    for (int i = 0; i < 32; i++) if (mag[i]) p = i; // Leading one
    if (p <= 23) begin
      k    = longint'(mag) << (23 - p);
      rem  = 0;
      half = 1;
    end else begin
      s = p - 23;
      k = mag >> s;
      rem = mag & ((64'd1 << s) - 1);
      half = 64'd1 << (s - 1);
    end
    k = k + round_inc(rm, sign, k[0], rem, half);
    if (k == (64'd1 << 24)) begin
      k = k >> 1; // Carry into the next binade
      p++;
    end
    r.result    = {sign, 8'(p + 127), k[22:0]};
    r.status.NX = (rem != 0);
    return r;
  endfunction

  function automatic fcvt_pkg::fcvt_resp_t model_f2i(logic [31:0] x, logic uns,
                                                      fcvt_pkg::rnd_mode_e rm);
    fcvt_pkg::fcvt_resp_t r;
    logic sign;
    int e;
    longint unsigned m, ip, rem, half, mag;
    r    = '0;
    sign = x[31];
    e    = (x[30:23] == 0) ? -126 : int'(x[30:23]) - 127;
    m    = {x[30:23] != 0, x[22:0]};
    if (x[30:23] == 8'hff || e >= (uns ? 32 : 31)) begin // NaN, inf, out of range
      r.status.NV = 1'b1;
      if (!sign || x[30:0] > 31'h7f800000) begin
        r.result = uns ? fcvt_pkg::UINT_MAX : fcvt_pkg::INT_MAX_S;
      end else begin
        r.result = uns ? '0 : fcvt_pkg::INT_MIN_S;
      end
      return r;
    end
    if (e >= 23) begin
      ip   = m << (e - 23);
      rem  = 0;
      half = 1;
    end else if (e <= -2) begin
      ip   = 0;
      rem  = (m != 0);
      half = 4; // Below one half, never a tie
    end else begin
      ip = m >> (23 - e);
      rem = m & ((64'd1 << (23 - e)) - 1);
      half = 64'd1 << (22 - e);
    end
    mag = ip + round_inc(rm, sign, ip[0], rem, half);
    if (uns && sign && mag != 0) begin
      r.status.NV = 1'b1; // Negative to unsigned
    end else begin
      r.result    = sign ? 32'(-mag) : 32'(mag);
      r.status.NX = (rem != 0);
    end
    return r;
  endfunction

  // --------------------------------------------------
  // Driver and scoreboard
  // --------------------------------------------------
  task automatic check_output();
    fcvt_pkg::fcvt_resp_t e;
    assert (exp_q.size() != 0) else begin
      $display("Response appeared at %0t with no request in flight", $time);
      err_hs++;
    end
    if (exp_q.size() == 0) return;
    e = exp_q.pop_front();
    assert (resp.result == e.result) else begin
      $display("ERROR %0t resp_o.result expected %h actual %h", $time, e.result, resp.result);
      err_result++;
    end
    assert (resp.status == e.status) else begin
      $display("ERROR %0t resp_o.status expected %b actual %b", $time, e.status, resp.status);
      err_status++;
    end
  endtask

  // Entered on a falling edge with inputs set, returns on the next one
  task automatic drive_cycle();
    out_ready = |rand_bits(2); // Ready three times in four
    #1;
    if (out_valid && out_ready) check_output(); // Taken at the coming edge
    accepted = in_valid && in_ready;
    if (accepted && !flush) begin
      if (req.op == fcvt_pkg::OP_I2F) begin
        exp_q.push_back(model_i2f(req.operand, req.op_mod, req.rnd_mode));
      end else begin
        exp_q.push_back(model_f2i(req.operand, req.op_mod, req.rnd_mode));
      end
    end
    @(negedge clk);
  endtask

  task automatic send(logic [31:0] x, fcvt_pkg::op_e op, logic uns, fcvt_pkg::rnd_mode_e rm);
    req = '{operand: x, op: op, op_mod: uns, rnd_mode: rm};
    in_valid = 1'b1;
    do drive_cycle(); while (!accepted); // Hold until taken
    in_valid = 1'b0;
  endtask

  task automatic flush_pipe();
    flush = 1'b1;
    drive_cycle();
    exp_q.delete(); // Everything in flight is gone
    flush = 1'b0;
    #1;
    assert (!busy) else begin
      $display("Pipeline still busy one cycle after flush at %0t", $time);
      err_hs++;
    end
  endtask

  logic [31:0] f2i_ops [16] = '{32'h3f800000, 32'h80000000, 32'h40100000, 32'h40200000,
    32'h40300000, 32'hc0200000, 32'h40600000, 32'h7fc00000, 32'h7f800001, 32'h7f800000,
    32'hff800000, 32'h4f000000, 32'hcf000000, 32'h4f800000, 32'hbe800000, 32'h00000001};
  logic [31:0] i2f_ops [8] = '{32'h0, 32'h1, 32'hffffffff, 32'h00ffffff, 32'h01000001,
    32'hfefffffd, 32'h80000000, 32'h7fffffff};

  initial begin
    req       = '0;
    in_valid  = 1'b0;
    flush     = 1'b0;
    out_ready = 1'b0;
    accepted  = 1'b0;
    wait (rst_n);
    @(negedge clk);
    foreach (f2i_ops[i]) for (int m = 0; m < 5; m++) for (int u = 0; u < 2; u++)
      send(f2i_ops[i], fcvt_pkg::OP_F2I, u[0], fcvt_pkg::rnd_mode_e'(m));
    flush_pipe();
    foreach (i2f_ops[i]) for (int m = 0; m < 5; m++) for (int u = 0; u < 2; u++)
      send(i2f_ops[i], fcvt_pkg::OP_I2F, u[0], fcvt_pkg::rnd_mode_e'(m));
    for (int n = 0; n < NUM_RANDOM; n++) begin
      logic [31:0] x;
      x = rand_bits(32);
      if (rand_bits(1)) x[30:23] = 8'(120 + rand_bits(4)); // Values with a fraction
      send(x, fcvt_pkg::op_e'(rand_bits(1)), rand_bits(1),
           fcvt_pkg::rnd_mode_e'(rand_bits(3) % 5));
      if (n % 100 == 99) flush_pipe();
    end
    while (exp_q.size() != 0 || busy) drive_cycle(); // Drain
    $display("Errors: result %0d, status %0d, handshake %0d, assertion %0d",
             err_result, err_status, err_hs, UUT.u_props.fail_cnt);
    if (err_result + err_status + err_hs + UUT.u_props.fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog, four cycles per test plus margin
  initial begin
    #((NUM_TESTS + 50) * 4 * 100);
    $display("Watchdog expired, the pipeline stopped making progress");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* filelist.f */
fcvt_pkg.sv
fcvt_lzc.sv
fcvt_normalizer.sv
fcvt_pipe_stage.sv
fcvt_cast_round.sv
fcvt_top.sv
tb_clk_gen.sv
tb_fcvt_properties.sv
tb_fcvt.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the FCVT testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fcvt -f filelist.f -o sim_fcvt \
  && ./obj_dir/sim_fcvt | tee sim.log \
  && grep -qF "*** TEST PASSED ***" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
